// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        S_MODE = 2'd1,
        M_MODE = 2'd3
    } mode_e;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,  // Write
        CMD_S     = 3'd2,  // Set bits
        CMD_C     = 3'd3,  // Clear bits
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5,
        CMD_SRET  = 3'd6
    } csr_cmd_e;

    // Same 12 bits, matched whole or split into the access fields
    typedef union packed {
        logic [CSR_ADDR_W-1:0] raw;
        struct packed {
            logic [1:0] rw;     // 2'b11 is read-only
            logic [1:0] priv;   // Lowest mode allowed in
            logic [7:0] index;
        } field;
    } csr_addr_u;

    // Supervisor registers
    localparam logic [CSR_ADDR_W-1:0] ADDR_SSTATUS  = 12'h100;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SIE      = 12'h104;
    localparam logic [CSR_ADDR_W-1:0] ADDR_STVEC    = 12'h105;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SSCRATCH = 12'h140;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SEPC     = 12'h141;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SCAUSE   = 12'h142;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SIP      = 12'h144;
    // Machine registers
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEDELEG  = 12'h302;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIDELEG  = 12'h303;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIP      = 12'h344;

    localparam logic [XLEN-1:0] CAUSE_SSI     = 32'h8000_0001;
    localparam logic [XLEN-1:0] CAUSE_MSI     = 32'h8000_0003;
    localparam logic [XLEN-1:0] CAUSE_STI     = 32'h8000_0005;
    localparam logic [XLEN-1:0] CAUSE_MTI     = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_SEI     = 32'h8000_0009;
    localparam logic [XLEN-1:0] CAUSE_MEI     = 32'h8000_000b;
    localparam logic [XLEN-1:0] CAUSE_ECALL_U = 32'h0000_0008;  // Plus mode for S and M

    // Bit positions in mip, mie and mideleg
    localparam int IRQ_SSI = 1;
    localparam int IRQ_MSI = 3;
    localparam int IRQ_STI = 5;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_SEI = 9;
    localparam int IRQ_MEI = 11;

    localparam logic [11:0] IRQ_MASK_ALL = 12'haaa;  // All six interrupt bits
    localparam logic [11:0] IRQ_MASK_S   = 12'h222;  // Supervisor subset

    localparam logic [1:0] TVEC_VECTORED = 2'b01;

endpackage

// ==== rtl/csr_access.sv ====
module csr_access
    import csr_pkg::*;
(
    input  csr_addr_u       addr,
    input  csr_cmd_e        cmd,
    input  logic            valid,
    input  logic [XLEN-1:0] wdata_in,
    input  mode_e           mode,
    input  logic [XLEN-1:0] rd_status,
    input  logic [XLEN-1:0] rd_trap_ctrl,
    input  logic [XLEN-1:0] rd_trap_regs,
    output logic [XLEN-1:0] rdata,
    output logic [XLEN-1:0] wdata,
    output logic            wr_en
);

    logic            can_access;
    logic            can_write;
    logic            is_write_cmd;
    logic [XLEN-1:0] rd_merged;

    // Privilege check straight from the address bits
    assign can_access = addr.field.priv <= mode;
    assign can_write  = can_access && (addr.field.rw != 2'b11);

    assign is_write_cmd = (cmd == CMD_W) || (cmd == CMD_S) || (cmd == CMD_C);

    // Blocks return zero for addresses they do not own
    assign rd_merged = rd_status | rd_trap_ctrl | rd_trap_regs;

    // Denied reads see zero
    assign rdata = can_access ? rd_merged : '0;

    // New register value
    always_comb begin
        case (cmd)
            CMD_W:   wdata = wdata_in;
            CMD_S:   wdata = rdata | wdata_in;   // Set bits
            CMD_C:   wdata = rdata & ~wdata_in;  // Clear bits
            default: wdata = '0;
        endcase
    end

    // Denied writes are silently dropped
    assign wr_en = valid && is_write_cmd && can_write;

    // Catch a write strobe reaching a read-only register
    always_comb begin
        assert final (!(wr_en && addr.field.rw == 2'b11))
            else $error("csr_access: write strobe on read-only CSR %h", addr.raw);
    end

endmodule

// ==== rtl/csr_trap_ctrl.sv ====
module csr_trap_ctrl
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid,
    input  csr_cmd_e        cmd,
    input  csr_addr_u       addr,
    input  logic [XLEN-1:0] wdata,
    input  logic            wr_en,
    input  mode_e           mode,
    input  logic            mstatus_mie,
    input  logic            mstatus_sie,
    input  logic            irq_meip,
    input  logic            irq_msip,
    input  logic            irq_mtip,
    output logic            take_trap,
    output logic            trap_to_m,
    output logic            is_irq,
    output logic [XLEN-1:0] trap_cause,
    output logic [XLEN-1:0] rd_data
);

    logic [XLEN-1:0] medeleg_r;
    logic [11:0]     mideleg_r;
    logic [11:0]     mie_r;
    logic [11:0]     spend_r;    // Software-writable S pending bits
    logic [11:0]     mpend_r;    // Machine pending, sampled from lines
    logic [11:0]     mip;
    logic [11:0]     pend_en;
    logic [XLEN-1:0] irq_cause;
    logic [3:0]      irq_code;
    logic [XLEN-1:0] ecall_cause;
    logic            irq_deleg;
    logic            m_en;
    logic            s_en;
    logic            irq_take;
    logic            ecall;

    assign mip     = mpend_r | spend_r;
    assign pend_en = mip & mie_r;

    // Fixed priority MEI, MSI, MTI, SEI, SSI, STI
    always_comb begin
        irq_cause = '0;
        if (pend_en[IRQ_MEI])      irq_cause = CAUSE_MEI;
        else if (pend_en[IRQ_MSI]) irq_cause = CAUSE_MSI;
        else if (pend_en[IRQ_MTI]) irq_cause = CAUSE_MTI;
        else if (pend_en[IRQ_SEI]) irq_cause = CAUSE_SEI;
        else if (pend_en[IRQ_SSI]) irq_cause = CAUSE_SSI;
        else if (pend_en[IRQ_STI]) irq_cause = CAUSE_STI;
    end
    assign irq_code  = irq_cause[3:0];
    assign irq_deleg = mideleg_r[irq_code];

    // Global enables per target level
    assign m_en = (mode == M_MODE) ? mstatus_mie : 1'b1;
    assign s_en = (mode == S_MODE) ? mstatus_sie : (mode == U_MODE);

    assign irq_take    = (|pend_en) && (irq_deleg ? s_en : m_en);
    assign ecall       = valid && (cmd == CMD_ECALL);
    assign ecall_cause = CAUSE_ECALL_U + {{(XLEN-2){1'b0}}, mode};

    // ECALL wins over a pending interrupt
    assign take_trap  = valid && (ecall || irq_take);
    assign is_irq     = take_trap && !ecall;
    assign trap_cause = ecall ? ecall_cause : irq_cause;
    assign trap_to_m  = (mode == M_MODE) ||
                        (ecall ? !medeleg_r[ecall_cause[4:0]] : !irq_deleg);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            medeleg_r <= '0;
            mideleg_r <= '0;
            mie_r     <= '0;
            spend_r   <= '0;
            mpend_r   <= '0;
        end else begin
            mpend_r <= '0;
            mpend_r[IRQ_MEI] <= irq_meip;  // Lines sampled every cycle
            mpend_r[IRQ_MSI] <= irq_msip;
            mpend_r[IRQ_MTI] <= irq_mtip;
            if (is_irq) begin
                spend_r[irq_code] <= 1'b0;  // Taken S interrupt clears its bit
            end else if (wr_en && !take_trap) begin
                case (addr.raw)
                    ADDR_MEDELEG:       medeleg_r <= wdata;
                    ADDR_MIDELEG:       mideleg_r <= wdata[11:0] & IRQ_MASK_ALL;
                    ADDR_MIE:           mie_r     <= wdata[11:0] & IRQ_MASK_ALL;
                    ADDR_SIE:           mie_r     <= (mie_r & ~IRQ_MASK_S) |
                                                     (wdata[11:0] & IRQ_MASK_S);
                    ADDR_MIP, ADDR_SIP: spend_r   <= wdata[11:0] & IRQ_MASK_S;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (addr.raw)
            ADDR_MEDELEG: rd_data = medeleg_r;
            ADDR_MIDELEG: rd_data = {{(XLEN-12){1'b0}}, mideleg_r};
            ADDR_MIE:     rd_data = {{(XLEN-12){1'b0}}, mie_r};
            ADDR_SIE:     rd_data = {{(XLEN-12){1'b0}}, mie_r & IRQ_MASK_S};
            ADDR_MIP:     rd_data = {{(XLEN-12){1'b0}}, mip};
            ADDR_SIP:     rd_data = {{(XLEN-12){1'b0}}, mip & IRQ_MASK_S};
            default:      rd_data = '0;
        endcase
    end

    // Mode after a trap must be the level this block chose
    assert property (@(posedge clk) disable iff (!rst_n)
        take_trap |=> (mode == ($past(trap_to_m) ? M_MODE : S_MODE)))
        else $error("csr_trap_ctrl: mode does not match trap target");

endmodule

// ==== rtl/csr_status.sv ====
module csr_status
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid,
    input  csr_cmd_e        cmd,
    input  csr_addr_u       addr,
    input  logic [XLEN-1:0] wdata,
    input  logic            wr_en,
    input  logic            take_trap,
    input  logic            trap_to_m,
    output mode_e           mode,
    output logic            mstatus_mie,
    output logic            mstatus_sie,
    output logic [XLEN-1:0] rd_data
);

    mode_e           mode_q;
    logic            mie_q;
    logic            sie_q;
    logic            mpie_q;
    logic            spie_q;
    logic [1:0]      mpp_q;
    logic            spp_q;
    logic            is_mret;
    logic            is_sret;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] sstatus;

    assign is_mret = valid && (cmd == CMD_MRET);
    assign is_sret = valid && (cmd == CMD_SRET);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode_q <= M_MODE;
            mie_q  <= 1'b0;
            sie_q  <= 1'b0;
            mpie_q <= 1'b0;
            spie_q <= 1'b0;
            mpp_q  <= 2'b00;
            spp_q  <= 1'b0;
        end else if (take_trap) begin
            if (trap_to_m) begin
                mpie_q <= mie_q;
                mie_q  <= 1'b0;
                mpp_q  <= mode_q;
                mode_q <= M_MODE;
            end else begin
                spie_q <= sie_q;
                sie_q  <= 1'b0;
                spp_q  <= mode_q[0];  // Only U or S trap to S
                mode_q <= S_MODE;
            end
        end else if (is_mret) begin
            mie_q  <= mpie_q;
            mode_q <= mode_e'(mpp_q);
            mpie_q <= 1'b1;
            mpp_q  <= U_MODE;
        end else if (is_sret) begin
            sie_q  <= spie_q;
            mode_q <= mode_e'({1'b0, spp_q});
            spie_q <= 1'b1;
            spp_q  <= 1'b0;
        end else if (wr_en) begin
            if (addr.raw == ADDR_MSTATUS) begin
                if (wdata[12:11] != 2'b10) mpp_q <= wdata[12:11];  // Reserved value kept out
                mpie_q <= wdata[7];
                mie_q  <= wdata[3];
            end
            if (addr.raw == ADDR_MSTATUS || addr.raw == ADDR_SSTATUS) begin
                spp_q  <= wdata[8];
                spie_q <= wdata[5];
                sie_q  <= wdata[1];
            end
        end
    end

    assign mstatus = {19'b0, mpp_q, 2'b0, spp_q, mpie_q, 1'b0, spie_q, 1'b0,
                      mie_q, 1'b0, sie_q, 1'b0};
    assign sstatus = mstatus & 32'h0000_0122;  // SPP, SPIE, SIE only

    assign rd_data = (addr.raw == ADDR_MSTATUS) ? mstatus :
                     (addr.raw == ADDR_SSTATUS) ? sstatus : '0;

    assign mode        = mode_q;
    assign mstatus_mie = mie_q;
    assign mstatus_sie = sie_q;

    // Encoding 2 is reserved
    assert property (@(posedge clk) disable iff (!rst_n) mode_q != 2'b10)
        else $error("csr_status: illegal mode encoding");

endmodule

// ==== rtl/csr_trap_regs.sv ====
module csr_trap_regs
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid,
    input  csr_cmd_e        cmd,
    input  csr_addr_u       addr,
    input  logic [XLEN-1:0] wdata,
    input  logic            wr_en,
    input  logic [XLEN-1:0] pc,
    input  logic            take_trap,
    input  logic            trap_to_m,
    input  logic            is_irq,
    input  logic [XLEN-1:0] trap_cause,
    output logic [XLEN-1:0] trap_vector,
    output logic [XLEN-1:0] rd_data
);

    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] stvec;
    logic [XLEN-1:0] sepc;
    logic [XLEN-1:0] scause;
    logic [XLEN-1:0] sscratch;
    logic [XLEN-1:0] m_vec;
    logic [XLEN-1:0] s_vec;
    logic            is_mret;
    logic            is_sret;

    // Base, plus 4 * code for a vectored interrupt
    function automatic logic [XLEN-1:0] tvec_target(input logic [XLEN-1:0] tvec,
                                                    input logic            irq,
                                                    input logic [XLEN-1:0] cause);
        logic [XLEN-1:0] base;
        base = {tvec[XLEN-1:2], 2'b00};
        if (irq && tvec[1:0] == TVEC_VECTORED)
            return base + {cause[XLEN-3:0], 2'b00};  // Interrupt flag shifted out
        return base;
    endfunction

    assign is_mret = valid && (cmd == CMD_MRET);
    assign is_sret = valid && (cmd == CMD_SRET);

    assign m_vec = tvec_target(mtvec, is_irq, trap_cause);
    assign s_vec = tvec_target(stvec, is_irq, trap_cause);

    assign trap_vector = take_trap ? (trap_to_m ? m_vec : s_vec) :
                         is_mret   ? mepc :
                         is_sret   ? sepc : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
            stvec    <= '0;
            sepc     <= '0;
            scause   <= '0;
            sscratch <= '0;
        end else if (take_trap) begin
            if (trap_to_m) begin
                mepc   <= pc;
                mcause <= trap_cause;
            end else begin
                sepc   <= pc;
                scause <= trap_cause;
            end
        end else if (wr_en) begin
            case (addr.raw)
                ADDR_MTVEC:    mtvec    <= wdata;
                ADDR_MEPC:     mepc     <= {wdata[XLEN-1:2], 2'b00};  // Word aligned
                ADDR_MCAUSE:   mcause   <= wdata;
                ADDR_MSCRATCH: mscratch <= wdata;
                ADDR_STVEC:    stvec    <= wdata;
                ADDR_SEPC:     sepc     <= wdata;
                ADDR_SCAUSE:   scause   <= wdata;
                ADDR_SSCRATCH: sscratch <= wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (addr.raw)
            ADDR_MTVEC:    rd_data = mtvec;
            ADDR_MEPC:     rd_data = mepc;
            ADDR_MCAUSE:   rd_data = mcause;
            ADDR_MSCRATCH: rd_data = mscratch;
            ADDR_STVEC:    rd_data = stvec;
            ADDR_SEPC:     rd_data = sepc;
            ADDR_SCAUSE:   rd_data = scause;
            ADDR_SSCRATCH: rd_data = sscratch;
            default:       rd_data = '0;
        endcase
    end

endmodule

// ==== rtl/csr_unit.sv ====
module csr_unit
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid,
    input  csr_cmd_e        cmd,
    input  csr_addr_u       addr,
    input  logic [XLEN-1:0] wdata_in,
    input  logic [XLEN-1:0] pc,
    input  logic            irq_meip,
    input  logic            irq_msip,
    input  logic            irq_mtip,
    output logic [XLEN-1:0] rdata,
    output logic            trap,
    output logic [XLEN-1:0] trap_vector,
    output mode_e           mode
);

    logic [XLEN-1:0] wdata;
    logic            wr_en;
    logic [XLEN-1:0] rd_status;
    logic [XLEN-1:0] rd_trap_ctrl;
    logic [XLEN-1:0] rd_trap_regs;
    logic            take_trap;
    logic            trap_to_m;
    logic            is_irq;
    logic [XLEN-1:0] trap_cause;
    logic            mstatus_mie;
    logic            mstatus_sie;
    logic            xret;

    assign xret = valid && (cmd == CMD_MRET || cmd == CMD_SRET);
    assign trap = take_trap | xret;  // Returns redirect the fetch too

    csr_access u_access (
        .addr(addr), .cmd(cmd), .valid(valid), .wdata_in(wdata_in), .mode(mode),
        .rd_status(rd_status), .rd_trap_ctrl(rd_trap_ctrl), .rd_trap_regs(rd_trap_regs),
        .rdata(rdata), .wdata(wdata), .wr_en(wr_en)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk(clk), .rst_n(rst_n), .valid(valid), .cmd(cmd), .addr(addr),
        .wdata(wdata), .wr_en(wr_en), .mode(mode),
        .mstatus_mie(mstatus_mie), .mstatus_sie(mstatus_sie),
        .irq_meip(irq_meip), .irq_msip(irq_msip), .irq_mtip(irq_mtip),
        .take_trap(take_trap), .trap_to_m(trap_to_m), .is_irq(is_irq),
        .trap_cause(trap_cause), .rd_data(rd_trap_ctrl)
    );

    csr_status u_status (
        .clk(clk), .rst_n(rst_n), .valid(valid), .cmd(cmd), .addr(addr),
        .wdata(wdata), .wr_en(wr_en), .take_trap(take_trap), .trap_to_m(trap_to_m),
        .mode(mode), .mstatus_mie(mstatus_mie), .mstatus_sie(mstatus_sie),
        .rd_data(rd_status)
    );

    csr_trap_regs u_trap_regs (
        .clk(clk), .rst_n(rst_n), .valid(valid), .cmd(cmd), .addr(addr),
        .wdata(wdata), .wr_en(wr_en), .pc(pc), .take_trap(take_trap),
        .trap_to_m(trap_to_m), .is_irq(is_irq), .trap_cause(trap_cause),
        .trap_vector(trap_vector), .rd_data(rd_trap_regs)
    );

endmodule

// ==== bench/csr_unit_tb.sv ====
module csr_unit_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_LIMIT = 20;  // Cycles allowed for reset release
    localparam int RUN_LIMIT   = 64;  // Cycles allowed for the whole table

    // One table row: inputs, then expectations
    typedef struct packed {
        csr_cmd_e        cmd;
        logic [11:0]     addr;
        logic [XLEN-1:0] operand;
        logic [XLEN-1:0] pc;
        logic [2:0]      irq;        // meip, msip, mtip
        logic [XLEN-1:0] exp_rdata;
        logic            exp_trap;
        logic [XLEN-1:0] exp_vec;    // Only meaningful with exp_trap
        mode_e           exp_mode;   // Mode after the edge
    } row_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            valid;
    csr_cmd_e        cmd;
    csr_addr_u       addr;
    logic [XLEN-1:0] wdata_in;
    logic [XLEN-1:0] pc;
    logic            irq_meip;
    logic            irq_msip;
    logic            irq_mtip;
    logic [XLEN-1:0] rdata;
    logic            trap;
    logic [XLEN-1:0] trap_vector;
    mode_e           mode;

    row_t rows[$];

    csr_unit u_csr_unit (
        .clk(clk), .rst_n(rst_n), .valid(valid), .cmd(cmd), .addr(addr),
        .wdata_in(wdata_in), .pc(pc), .irq_meip(irq_meip), .irq_msip(irq_msip),
        .irq_mtip(irq_mtip), .rdata(rdata), .trap(trap), .trap_vector(trap_vector),
        .mode(mode)
    );

    always #50 clk = ~clk;  // 100 ns period

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

    task automatic abort_run(input string why);
        $display("** FAIL **");
        $fatal(1, "%s", why);
    endtask

    task automatic compare(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: %s, expected %h, got %h", $time, what, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    task automatic add_row(input csr_cmd_e c, input logic [11:0] a,
                           input logic [XLEN-1:0] op, input logic [XLEN-1:0] pcv,
                           input logic [2:0] irq, input logic [XLEN-1:0] rd,
                           input logic tr, input logic [XLEN-1:0] vec, input mode_e md);
        row_t r;
        r = '{cmd: c, addr: a, operand: op, pc: pcv, irq: irq, exp_rdata: rd,
              exp_trap: tr, exp_vec: vec, exp_mode: md};
        rows.push_back(r);
    endtask

    initial begin
        logic [XLEN-1:0] pat [0:7];
        logic [XLEN-1:0] ms;
        logic [XLEN-1:0] ss;
        logic [XLEN-1:0] mtv;
        logic [XLEN-1:0] stv;
        logic [XLEN-1:0] mbase;
        logic [XLEN-1:0] pc_ret;
        logic [XLEN-1:0] pc_ecall;
        logic [XLEN-1:0] pc_msi;
        logic [XLEN-1:0] pc_mei;
        logic [XLEN-1:0] mie_bits;
        row_t            r;
        int              cycles;
        int              k;
        int              i;

        valid    = 1'b0;
        cmd      = CMD_NONE;
        addr     = '0;
        wdata_in = '0;
        pc       = '0;
        irq_meip = 1'b0;
        irq_msip = 1'b0;
        irq_mtip = 1'b0;

        void'($urandom(32'ha716_477d));  // Seed once
        for (k = 0; k < 8; k++) pat[k] = $urandom;
        mtv      = ($urandom & 32'hffff_ff00) | 32'h1;  // Vectored
        stv      = $urandom & 32'hffff_fffc;            // Direct
        mbase    = mtv & 32'hffff_fffc;
        pc_ret   = $urandom & 32'hffff_fffc;
        pc_ecall = $urandom & 32'hffff_fffc;
        pc_msi   = $urandom & 32'hffff_fffc;
        pc_mei   = $urandom & 32'hffff_fffc;
        mie_bits = (32'h1 << IRQ_MSI) | (32'h1 << IRQ_MTI) | (32'h1 << IRQ_MEI);

        // Scratch write/set/clear in M-mode, rdata shows the old value
        ms = '0;
        add_row(CMD_W, ADDR_MSCRATCH, pat[0], '0, 3'b000, ms, 1'b0, '0, M_MODE);
        ms = pat[0];
        add_row(CMD_S, ADDR_MSCRATCH, pat[1], '0, 3'b000, ms, 1'b0, '0, M_MODE);
        ms = ms | pat[1];
        add_row(CMD_C, ADDR_MSCRATCH, pat[2], '0, 3'b000, ms, 1'b0, '0, M_MODE);
        ms = ms & ~pat[2];
        add_row(CMD_NONE, ADDR_MSCRATCH, '0, '0, 3'b000, ms, 1'b0, '0, M_MODE);
        ss = '0;
        add_row(CMD_W, ADDR_SSCRATCH, pat[3], '0, 3'b000, ss, 1'b0, '0, M_MODE);
        ss = pat[3];
        add_row(CMD_S, ADDR_SSCRATCH, pat[4], '0, 3'b000, ss, 1'b0, '0, M_MODE);
        ss = ss | pat[4];
        add_row(CMD_C, ADDR_SSCRATCH, pat[5], '0, 3'b000, ss, 1'b0, '0, M_MODE);
        ss = ss & ~pat[5];
        add_row(CMD_NONE, ADDR_SSCRATCH, '0, '0, 3'b000, ss, 1'b0, '0, M_MODE);

        // Setup for later traps, lines still low
        add_row(CMD_W, ADDR_MEDELEG, 32'h100, '0, 3'b000, '0, 1'b0, '0, M_MODE);  // U ecall
        add_row(CMD_W, ADDR_STVEC, stv, '0, 3'b000, '0, 1'b0, '0, M_MODE);
        add_row(CMD_W, ADDR_MTVEC, mtv, '0, 3'b000, '0, 1'b0, '0, M_MODE);
        add_row(CMD_W, ADDR_MIE, mie_bits, '0, 3'b000, '0, 1'b0, '0, M_MODE);
        add_row(CMD_W, ADDR_MSTATUS, 32'h0, '0, 3'b000, '0, 1'b0, '0, M_MODE);  // MPP = U
        add_row(CMD_W, ADDR_MEPC, pc_ret, '0, 3'b000, '0, 1'b0, '0, M_MODE);
        add_row(CMD_MRET, 12'h000, '0, '0, 3'b000, '0, 1'b1, pc_ret, U_MODE);

        // U-mode cannot see or change mscratch
        add_row(CMD_NONE, ADDR_MSCRATCH, '0, '0, 3'b000, '0, 1'b0, '0, U_MODE);
        add_row(CMD_W, ADDR_MSCRATCH, pat[6], '0, 3'b000, '0, 1'b0, '0, U_MODE);

        // Delegated ecall lands in S, SRET goes back
        add_row(CMD_ECALL, 12'h000, '0, pc_ecall, 3'b000, '0, 1'b1, stv, S_MODE);
        add_row(CMD_NONE, ADDR_SEPC, '0, '0, 3'b000, pc_ecall, 1'b0, '0, S_MODE);
        add_row(CMD_NONE, ADDR_SCAUSE, '0, '0, 3'b000, 32'd8, 1'b0, '0, S_MODE);
        add_row(CMD_SRET, 12'h000, '0, '0, 3'b000, '0, 1'b1, pc_ecall, U_MODE);

        // MSI and MTI from U, lines are registered so the trap comes a row later
        add_row(CMD_NONE, 12'h000, '0, '0, 3'b011, '0, 1'b0, '0, U_MODE);
        add_row(CMD_NONE, 12'h000, '0, pc_msi, 3'b011, '0, 1'b1, mbase + 32'd12, M_MODE);
        add_row(CMD_NONE, ADDR_MCAUSE, '0, '0, 3'b000, CAUSE_MSI, 1'b0, '0, M_MODE);
        add_row(CMD_NONE, ADDR_MEPC, '0, '0, 3'b000, pc_msi, 1'b0, '0, M_MODE);
        add_row(CMD_NONE, ADDR_MSCRATCH, '0, '0, 3'b000, ms, 1'b0, '0, M_MODE);

        // MEI in M-mode, blocked until MIE set; mstatus holds only SPIE here
        add_row(CMD_NONE, 12'h000, '0, '0, 3'b100, '0, 1'b0, '0, M_MODE);
        add_row(CMD_NONE, ADDR_MSTATUS, '0, '0, 3'b100, 32'h20, 1'b0, '0, M_MODE);
        add_row(CMD_S, ADDR_MSTATUS, 32'h8, '0, 3'b100, 32'h20, 1'b0, '0, M_MODE);
        // Trap wins, the scratch write is dropped
        add_row(CMD_W, ADDR_MSCRATCH, pat[7], pc_mei, 3'b100, ms, 1'b1, mbase + 32'd44,
                M_MODE);
        add_row(CMD_NONE, ADDR_MCAUSE, '0, '0, 3'b000, CAUSE_MEI, 1'b0, '0, M_MODE);
        add_row(CMD_NONE, ADDR_MSCRATCH, '0, '0, 3'b000, ms, 1'b0, '0, M_MODE);
        add_row(CMD_NONE, ADDR_MEPC, '0, '0, 3'b000, pc_mei, 1'b0, '0, M_MODE);

        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_LIMIT) begin
                $display("Timeout: reset was not released within %0d cycles", RESET_LIMIT);
                abort_run("reset timeout");
            end
        end

        cycles = 0;
        for (i = 0; i < rows.size(); i++) begin
            r = rows[i];
            @(posedge clk);
            valid    <= 1'b1;
            cmd      <= r.cmd;
            addr.raw <= r.addr;
            wdata_in <= r.operand;
            pc       <= r.pc;
            {irq_meip, irq_msip, irq_mtip} <= r.irq;
            @(negedge clk);  // Outputs settled
            if (i > 0) begin
                compare(32'(mode), 32'(rows[i-1].exp_mode), $sformatf("row %0d mode", i - 1));
            end
            compare(rdata, r.exp_rdata, $sformatf("row %0d rdata", i));
            compare(32'(trap), 32'(r.exp_trap), $sformatf("row %0d trap", i));
            if (r.exp_trap) compare(trap_vector, r.exp_vec, $sformatf("row %0d vector", i));
            cycles++;
            if (cycles > RUN_LIMIT) begin
                $display("Timeout: table did not finish within %0d cycles", RUN_LIMIT);
                abort_run("run timeout");
            end
        end

        // Idle cycle to see the last mode
        @(posedge clk);
        valid    <= 1'b0;
        cmd      <= CMD_NONE;
        {irq_meip, irq_msip, irq_mtip} <= 3'b000;
        @(negedge clk);
        compare(32'(mode), 32'(rows[rows.size()-1].exp_mode), "last row mode");

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/csr_pkg.sv
rtl/csr_access.sv
rtl/csr_trap_ctrl.sv
rtl/csr_status.sv
rtl/csr_trap_regs.sv
rtl/csr_unit.sv
bench/csr_unit_tb.sv

// ==== Makefile ====
TOP := csr_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^\*\* PASS \*\*$$'

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
